/* dv/lsu_tb_model.svh */
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// Architectural copy of registers and data memory
word_t       model_regs [`LSU_REG_COUNT];
word_t       model_mem [256];
dcache_req_t exp_req [$];
wb_t         exp_wb [$];

// Every bit of the word index shows up in the fill
function automatic word_t fill_word(int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a ^ 8'h5a, ~a, {a[3:0], a[7:4]}, a + 8'h81};
endfunction

task automatic model_execute(input issue_t op);
    word_t       a;
    word_t       b;
    word_t       sum;
    word_t       word;
    word_t       lane;
    word_t       val;
    logic [1:0]  off;
    dcache_req_t req;
    wb_t         w;
    a   = (op.rs1 == 0) ? '0 : model_regs[op.rs1];
    b   = (op.rs2 == 0) ? '0 : model_regs[op.rs2];
    sum = a + ((op.kind == op_add) ? b : op.imm);
    off = sum[1:0];
    req.addr    = {sum[31:2], 2'b00};
    req.byte_en = 4'b0000;
    req.wdata   = '0;
    if (op.kind == op_store)
    begin
        req.ctrl  = dc_write;
        req.wdata = b << (8 * off);
        case (op.funct.store)
            st_word: req.byte_en = 4'b1111;
            st_half: req.byte_en = (off == 0) ? 4'b0011 : (off == 1) ? 4'b0110 :
                                   (off == 2) ? 4'b1100 : 4'b0000;
            default: req.byte_en = 4'b0001 << off;
        endcase
        exp_req.push_back(req);
        for (int i = 0; i < 4; i++)
        begin
            if (req.byte_en[i])
                model_mem[req.addr[9:2]][8*i +: 8] = req.wdata[8*i +: 8];
        end
    end
    else if (op.kind == op_load)
    begin
        req.ctrl = dc_read;
        exp_req.push_back(req);
        word = model_mem[req.addr[9:2]];
        lane = word >> (8 * off);
        case (op.funct.load)
            ld_byte:  val = {{24{lane[7]}}, lane[7:0]};
            ld_ubyte: val = {24'h0, lane[7:0]};
            ld_half:  val = (off == 3) ? '0 : {{16{lane[15]}}, lane[15:0]};
            ld_uhalf: val = (off == 3) ? '0 : {16'h0, lane[15:0]};
            default:  val = word;
        endcase
        if (op.rd != 0)
        begin
            model_regs[op.rd] = val;
            w.valid = 1'b1;
            w.rd    = op.rd;
            w.data  = val;
            exp_wb.push_back(w);
        end
    end
    else if ((op.kind == op_addi || op.kind == op_add) && op.rd != 0)
    begin
        model_regs[op.rd] = sum;
        w.valid = 1'b1;
        w.rd    = op.rd;
        w.data  = sum;
        exp_wb.push_back(w);
    end
endtask

`endif

/* dv/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb
    import lsu_pkg::*;
();

    logic        CLK;
    logic        rst;
    issue_t      issue;
    logic        data_ready;
    word_t       data_rdata;
    logic        pipeline_stall;
    dcache_req_t dcache_req;
    wb_t         wb;

    `include "lsu_tb_model.svh"

    logic [31:0] lfsr_state;
    word_t       tb_mem [256];
    word_t       rd_pipe [4];
    issue_t      cur_issue;
    logic        bp_on;
    logic        accepted;
    logic        stall_seen;
    logic        zero_be_seen;
    int          errs;
    int          tests_passed;
    int          tests_failed;

    lsu_top UUT (
        .CLK            (CLK),
        .rst            (rst),
        .issue          (issue),
        .data_ready     (data_ready),
        .data_rdata     (data_rdata),
        .pipeline_stall (pipeline_stall),
        .dcache_req     (dcache_req),
        .wb             (wb)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic issue_t make_op(op_kind_e kind, logic [2:0] funct, reg_addr_t rd,
                                       reg_addr_t rs1, reg_addr_t rs2, word_t imm);
        issue_t op;
        op.valid = 1'b1;
        op.kind  = kind;
        op.funct = funct;
        op.rd    = rd;
        op.rs1   = rs1;
        op.rs2   = rs2;
        op.imm   = imm;
        return op;
    endfunction

    ////////////////////
    // Output checks
    ////////////////////

    task automatic check_outputs();
        dcache_req_t er;
        wb_t         ew;
        if (data_ready && dcache_req.ctrl != dc_idle)
        begin
            if (exp_req.size() == 0)
            begin
                $display("Unexpected data cache request at %0t ns", $time);
                errs++;
            end
            else
            begin
                er = exp_req.pop_front();
                if (dcache_req.ctrl != er.ctrl || dcache_req.addr != er.addr)
                begin
                    $display("** Error at %0t ns: request ctrl %0d addr %h, expected %0d %h",
                             $time, dcache_req.ctrl, dcache_req.addr, er.ctrl, er.addr);
                    errs++;
                end
                if (er.ctrl == dc_write &&
                    (dcache_req.byte_en != er.byte_en || dcache_req.wdata != er.wdata))
                begin
                    $display("** Error at %0t ns: store be %b data %h, expected %b %h", $time,
                             dcache_req.byte_en, dcache_req.wdata, er.byte_en, er.wdata);
                    errs++;
                end
                if (er.ctrl == dc_write && er.byte_en == 4'b0000)
                    zero_be_seen = 1'b1;
            end
        end
        if (wb.valid)
        begin
            if (exp_wb.size() == 0)
            begin
                $display("Writeback to x%0d at %0t ns was not expected", wb.rd, $time);
                errs++;
            end
            else
            begin
                ew = exp_wb.pop_front();
                if (wb.rd != ew.rd || wb.data != ew.data)
                begin
                    $display("** Error at %0t ns: writeback x%0d = %h, expected x%0d = %h",
                             $time, wb.rd, wb.data, ew.rd, ew.data);
                    errs++;
                end
            end
        end
    endtask

    // Memory side that advances only on ready cycles
    task automatic respond();
        if (data_ready)
        begin
            if (dcache_req.ctrl == dc_write)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (dcache_req.byte_en[i])
                        tb_mem[dcache_req.addr[9:2]][8*i +: 8] = dcache_req.wdata[8*i +: 8];
                end
            end
            rd_pipe[3] = rd_pipe[2];
            rd_pipe[2] = rd_pipe[1];
            rd_pipe[1] = rd_pipe[0];
            rd_pipe[0] = (dcache_req.ctrl == dc_read) ? tb_mem[dcache_req.addr[9:2]] : '0;
        end
    endtask

    task automatic cycle_step();
        @(negedge CLK);
        data_rdata = rd_pipe[3];
        data_ready = bp_on ? (take_bits(2) != 0) : 1'b1;
        issue      = cur_issue;
        #2;
        if (pipeline_stall && data_ready)
            stall_seen = 1'b1;
        check_outputs();
        accepted = issue.valid && !pipeline_stall;
        if (accepted)
            model_execute(issue);
        respond();
    endtask

    task automatic issue_op(input issue_t op);
        int tries;
        cur_issue = op;
        accepted  = 1'b0;
        tries     = 0;
        while (!accepted && tries < 100)
        begin
            cycle_step();
            tries++;
        end
        if (!accepted)
        begin
            $display("Operation was never accepted by the DUT");
            errs++;
        end
        cur_issue = '0;
    endtask

    // Kind weights in sixteenths
    task automatic run_random(int n, int w_load, int w_store, int w_add);
        int          r;
        op_kind_e    kind;
        logic [2:0]  funct;
        logic [31:0] bits;
        logic [5:0]  imm;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        for (int i = 0; i < n; i++)
        begin
            r = take_bits(4);
            if (r < w_load)
                kind = op_load;
            else if (r < w_load + w_store)
                kind = op_store;
            else if (r < w_load + w_store + w_add)
                kind = op_add;
            else
                kind = op_addi;
            r = take_bits(3) % 5;
            funct = (kind == op_load) ? ((r < 3) ? r[2:0] : r[2:0] + 3'd1) : r[2:0] % 3'd3;
            bits  = take_bits(6);
            imm   = bits[5:0];
            bits  = take_bits(3);
            rd    = {2'b00, bits[2:0]};
            bits  = take_bits(3);
            rs1   = {2'b00, bits[2:0]};
            bits  = take_bits(3);
            rs2   = {2'b00, bits[2:0]};
            issue_op(make_op(kind, funct, rd, rs1, rs2, {{26{imm[5]}}, imm}));
            if (take_bits(2) == 0)
                cycle_step();
        end
    endtask

    task automatic drain();
        int waits;
        waits = 0;
        while ((exp_req.size() != 0 || exp_wb.size() != 0) && waits < 200)
        begin
            cycle_step();
            waits++;
        end
        if (waits >= 200)
        begin
            $display("Pipeline did not drain, %0d requests and %0d writebacks missing",
                     exp_req.size(), exp_wb.size());
            errs++;
        end
        // Catch repeated writebacks
        repeat (8) cycle_step();
    endtask

    task automatic end_test(input string name, input int start_errs, input logic extra_ok);
        if (errs == start_errs && extra_ok)
        begin
            $display("Test %s: passed", name);
            tests_passed++;
        end
        else
        begin
            $display("Test %s: failed", name);
            tests_failed++;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        int start;
        rst          = 1'b1;
        issue        = '0;
        data_ready   = 1'b1;
        data_rdata   = '0;
        cur_issue    = '0;
        bp_on        = 1'b0;
        stall_seen   = 1'b0;
        zero_be_seen = 1'b0;
        errs         = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr_state   = 32'he649_9989;
        for (int i = 0; i < 256; i++)
        begin
            tb_mem[i]    = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < `LSU_REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < 4; i++)
            rd_pipe[i] = '0;

        repeat (4) @(negedge CLK);
        rst   = 1'b0;
        start = errs;
        cycle_step();
        if (wb.valid || dcache_req.ctrl != dc_idle || pipeline_stall)
        begin
            $display("** Error at %0t ns: outputs not idle after reset", $time);
            errs++;
        end
        end_test("reset", start, 1'b1);

        start = errs;
        run_random(150, 0, 0, 8);
        drain();
        end_test("alu_forwarding", start, 1'b1);

        start = errs;
        issue_op(make_op(op_addi, 3'd0, 5'd1, 5'd0, 5'd0, 32'd3));
        issue_op(make_op(op_store, st_half, 5'd0, 5'd1, 5'd2, 32'd0));
        run_random(150, 0, 8, 2);
        drain();
        end_test("stores", start, zero_be_seen);

        start = errs;
        issue_op(make_op(op_addi, 3'd0, 5'd1, 5'd0, 5'd0, 32'd7));
        issue_op(make_op(op_load, ld_half, 5'd3, 5'd1, 5'd0, 32'd0));
        issue_op(make_op(op_load, ld_uhalf, 5'd4, 5'd1, 5'd0, 32'd0));
        run_random(150, 8, 4, 2);
        drain();
        end_test("loads", start, 1'b1);

        start      = errs;
        stall_seen = 1'b0;
        for (int i = 0; i < 40; i++)
        begin
            issue_op(make_op(op_load, ld_word, 5'd5, 5'd1, 5'd0, 32'd4 * i));
            issue_op(make_op(op_add, 3'd0, 5'd6, 5'd5, 5'd2, 32'd0));
        end
        run_random(100, 8, 2, 4);
        drain();
        end_test("load_use", start, stall_seen);

        start = errs;
        bp_on = 1'b1;
        run_random(300, 5, 4, 4);
        drain();
        bp_on = 1'b0;
        end_test("back_pressure", start, 1'b1);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errs);
        if (tests_failed == 0 && errs == 0)
        begin
            $display("ALL CHECKS PASSED");
        end
        else
        begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* include/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

////////////////////
// Datapath widths
////////////////////

// Data and address word
`define LSU_XLEN 32

// Architectural registers
`define LSU_REG_COUNT 32
`define LSU_REG_ADDR_W 5

////////////////////
// Pipeline depth
////////////////////

// Memory stages between EX and WB
`define LSU_MEM_STAGES 3

`endif

/* run_sim.sh */
#!/bin/bash
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")"

verilator --binary -f vlog.f --top-module lsu_tb -Mdir obj_dir -o Vlsu_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vlsu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi

exit 0

/* source/exec_stage.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module exec_stage
    import lsu_pkg::*;
(
    input  ex_op_t      ex_op,
    output word_t       ex_result,
    output stage_t      ex_stage,
    output dcache_req_t dcache_req
);

    word_t      sum;
    logic [1:0] offset;
    logic [3:0] byte_en;
    logic       is_load;
    logic       is_store;

    assign sum       = ex_op.rs1_val + ((ex_op.kind == op_add) ? ex_op.rs2_val : ex_op.imm);
    assign offset    = sum[1:0];
    assign ex_result = sum;

    assign is_load  = ex_op.valid && ex_op.kind == op_load;
    assign is_store = ex_op.valid && ex_op.kind == op_store;

    // Lane enables for the store size
    always_comb
    begin
        case (ex_op.funct.store)
            st_word: byte_en = 4'b1111;
            st_half: byte_en = (offset == 2'd3) ? 4'b0000 : (4'b0011 << offset);
            st_byte: byte_en = 4'b0001 << offset;
            default: byte_en = 4'b0000;
        endcase
    end

    always_comb
    begin
        if (is_load)
            dcache_req.ctrl = dc_read;
        else if (is_store)
            dcache_req.ctrl = dc_write;
        else
            dcache_req.ctrl = dc_idle;
        dcache_req.addr    = {sum[`LSU_XLEN-1:2], 2'b00};
        dcache_req.byte_en = is_store ? byte_en : 4'b0000;
        dcache_req.wdata   = ex_op.rs2_val << {offset, 3'b000};
    end

    always_comb
    begin
        ex_stage.valid  = ex_op.valid;
        ex_stage.kind   = ex_op.kind;
        ex_stage.funct  = ex_op.funct;
        ex_stage.rd     = ex_op.rd;
        ex_stage.result = sum;
        ex_stage.offset = offset;
    end

endmodule

/* source/load_align.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module load_align
    import lsu_pkg::*;
(
    input  stage_t wb_stage,
    input  logic   data_ready,
    input  word_t  data_rdata,
    output wb_t    wb,
    output word_t  wb_data
);

    word_t lane;
    word_t load_data;
    logic  writes_rd;

    // Addressed byte moved down to lane 0
    assign lane = data_rdata >> {wb_stage.offset, 3'b000};

    always_comb
    begin
        case (wb_stage.funct.load)
            ld_byte:  load_data = {{(`LSU_XLEN-8){lane[7]}}, lane[7:0]};
            ld_ubyte: load_data = {{(`LSU_XLEN-8){1'b0}}, lane[7:0]};
            ld_half:
            begin
                if (wb_stage.offset == 2'd3)
                    load_data = '0;
                else
                    load_data = {{(`LSU_XLEN-16){lane[15]}}, lane[15:0]};
            end
            ld_uhalf:
            begin
                if (wb_stage.offset == 2'd3)
                    load_data = '0;
                else
                    load_data = {{(`LSU_XLEN-16){1'b0}}, lane[15:0]};
            end
            default:  load_data = data_rdata;
        endcase
    end

    assign wb_data = (wb_stage.kind == op_load) ? load_data : wb_stage.result;

    assign writes_rd = wb_stage.valid && wb_stage.rd != '0 &&
                       (wb_stage.kind == op_addi || wb_stage.kind == op_add ||
                        wb_stage.kind == op_load);

    // Frozen cycle must not write again
    assign wb.valid = writes_rd && data_ready;
    assign wb.rd    = wb_stage.rd;
    assign wb.data  = wb_data;

endmodule

/* source/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [`LSU_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        op_nop   = 3'd0,
        op_addi  = 3'd1,
        op_add   = 3'd2,
        op_load  = 3'd3,
        op_store = 3'd4
    } op_kind_e;

    // RISC-V funct3 codes
    typedef enum logic [2:0] {
        ld_byte  = 3'b000,
        ld_half  = 3'b001,
        ld_word  = 3'b010,
        ld_ubyte = 3'b100,
        ld_uhalf = 3'b101
    } load_size_e;

    typedef enum logic [2:0] {
        st_byte = 3'b000,
        st_half = 3'b001,
        st_word = 3'b010
    } store_size_e;

    // Same funct3, read as load or store size
    typedef union packed {
        load_size_e  load;
        store_size_e store;
    } mem_funct_u;

    typedef enum logic [1:0] {
        dc_idle  = 2'b00,
        dc_read  = 2'b01,
        dc_write = 2'b10
    } dcache_ctrl_e;

    typedef struct packed {
        logic       valid;
        op_kind_e   kind;
        mem_funct_u funct;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
    } issue_t;

    typedef struct packed {
        logic       valid;
        op_kind_e   kind;
        mem_funct_u funct;
        reg_addr_t  rd;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
    } ex_op_t;

    typedef struct packed {
        logic       valid;
        op_kind_e   kind;
        mem_funct_u funct;
        reg_addr_t  rd;
        word_t      result;
        logic [1:0] offset;
    } stage_t;

    typedef struct packed {
        dcache_ctrl_e               ctrl;
        word_t                      addr;
        logic [`LSU_XLEN/8-1:0]     byte_en;
        word_t                      wdata;
    } dcache_req_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

/* source/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic        CLK,
    input  logic        rst,
    input  issue_t      issue,
    input  logic        data_ready,
    input  word_t       data_rdata,
    output logic        pipeline_stall,
    output dcache_req_t dcache_req,
    output wb_t         wb
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    ex_op_t    ex_op;
    word_t     ex_result;
    stage_t    ex_stage;
    stage_t    stages [0:`LSU_MEM_STAGES];
    stage_t    wb_stage;
    word_t     wb_data;

    reg_file u_reg_file (
        .CLK        (CLK),
        .rst        (rst),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .wb         (wb),
        .data_ready (data_ready),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    operand_stage u_operand_stage (
        .CLK            (CLK),
        .rst            (rst),
        .issue          (issue),
        .data_ready     (data_ready),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .ex_result      (ex_result),
        .stages         (stages),
        .wb_data        (wb_data),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .pipeline_stall (pipeline_stall),
        .ex_op          (ex_op)
    );

    exec_stage u_exec_stage (
        .ex_op      (ex_op),
        .ex_result  (ex_result),
        .ex_stage   (ex_stage),
        .dcache_req (dcache_req)
    );

    mem_pipe u_mem_pipe (
        .CLK        (CLK),
        .rst        (rst),
        .data_ready (data_ready),
        .ex_stage   (ex_stage),
        .stages     (stages),
        .wb_stage   (wb_stage)
    );

    load_align u_load_align (
        .wb_stage   (wb_stage),
        .data_ready (data_ready),
        .data_rdata (data_rdata),
        .wb         (wb),
        .wb_data    (wb_data)
    );

endmodule

/* source/mem_pipe.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module mem_pipe
    import lsu_pkg::*;
(
    input  logic   CLK,
    input  logic   rst,
    input  logic   data_ready,
    input  stage_t ex_stage,
    output stage_t stages [0:`LSU_MEM_STAGES],
    output stage_t wb_stage
);

    // MEM1 .. MEM3, then WB in the last slot
    localparam int DEPTH = `LSU_MEM_STAGES + 1;

    ////////////////////
    // Stage chain
    ////////////////////

    // Whole chain freezes on low data_ready
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                stages[i].valid <= 1'b0;
            end
        end
        else if (data_ready)
        begin
            stages[0] <= ex_stage;
            for (int i = 1; i < DEPTH; i++)
            begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign wb_stage = stages[DEPTH-1];

endmodule

/* source/operand_stage.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module operand_stage
    import lsu_pkg::*;
(
    input  logic      CLK,
    input  logic      rst,
    input  issue_t    issue,
    input  logic      data_ready,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     ex_result,
    input  stage_t    stages [0:`LSU_MEM_STAGES],
    input  word_t     wb_data,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      pipeline_stall,
    output ex_op_t    ex_op
);

    localparam int WB_IDX = `LSU_MEM_STAGES;

    logic   uses_rs1;
    logic   uses_rs2;
    logic   load_hazard;
    logic   accept;
    word_t  rs1_val;
    word_t  rs2_val;
    ex_op_t next_op;

    function automatic logic is_alu(op_kind_e kind);
        return kind == op_addi || kind == op_add;
    endfunction

    ////////////////////
    // Forwarding
    ////////////////////

    // Walk oldest to youngest, last hit wins
    function automatic word_t forward(reg_addr_t src, word_t rf_data);
        word_t val;
        val = rf_data;
        if (stages[WB_IDX].valid && stages[WB_IDX].rd == src &&
            (is_alu(stages[WB_IDX].kind) || stages[WB_IDX].kind == op_load))
        begin
            val = wb_data;
        end
        for (int i = WB_IDX - 1; i >= 0; i--)
        begin
            if (stages[i].valid && is_alu(stages[i].kind) && stages[i].rd == src)
            begin
                val = stages[i].result;
            end
        end
        if (ex_op.valid && is_alu(ex_op.kind) && ex_op.rd == src)
        begin
            val = ex_result;
        end
        if (src == '0)
        begin
            val = '0;
        end
        return val;
    endfunction

    // Load still short of WB
    function automatic logic load_pending(reg_addr_t src);
        logic hit;
        hit = ex_op.valid && ex_op.kind == op_load && ex_op.rd == src;
        for (int i = 0; i < WB_IDX; i++)
        begin
            hit = hit || (stages[i].valid && stages[i].kind == op_load && stages[i].rd == src);
        end
        return hit && src != '0;
    endfunction

    assign rs1_addr = issue.rs1;
    assign rs2_addr = issue.rs2;

    assign uses_rs1 = issue.kind != op_nop;
    assign uses_rs2 = issue.kind == op_add || issue.kind == op_store;

    always_comb
    begin
        rs1_val     = forward(issue.rs1, rs1_data);
        rs2_val     = forward(issue.rs2, rs2_data);
        load_hazard = issue.valid &&
                      ((uses_rs1 && load_pending(issue.rs1)) ||
                       (uses_rs2 && load_pending(issue.rs2)));
    end

    assign pipeline_stall = load_hazard || !data_ready;
    assign accept         = issue.valid && !load_hazard;

    ////////////////////
    // EX register
    ////////////////////

    always_comb
    begin
        next_op.valid   = accept;
        next_op.kind    = accept ? issue.kind : op_nop;
        next_op.funct   = issue.funct;
        next_op.rd      = issue.rd;
        next_op.rs1_val = rs1_val;
        next_op.rs2_val = rs2_val;
        next_op.imm     = issue.imm;
    end

    // Bubble goes in when nothing is accepted
    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            ex_op.valid <= 1'b0;
        end
        else if (data_ready)
        begin
            ex_op <= next_op;
        end
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps
`include "lsu_settings.svh"

module reg_file
    import lsu_pkg::*;
(
    input  logic      CLK,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  wb_t       wb,
    input  logic      data_ready,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [`LSU_REG_COUNT];

    always_ff @(posedge CLK)
    begin
        if (rst)
        begin
            for (int i = 0; i < `LSU_REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.valid && data_ready && wb.rd != '0)
        begin
            regs[wb.rd] <= wb.data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* vlog.f */
+incdir+include
+incdir+dv
source/lsu_pkg.sv
source/reg_file.sv
source/operand_stage.sv
source/exec_stage.sv
source/mem_pipe.sv
source/load_align.sv
source/lsu_top.sv
dv/lsu_tb.sv
